// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_cpu_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/reg_file.sv
rtl/operand_bypass.sv
rtl/execute_alu.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/cpu_core.sv
tests/tb_cpu_core.sv

// ==== rtl/cpu_core.sv ====
`timescale 1ns/100ps

module cpu_core (
    input  logic           clock_i,
    input  logic           arst_n_i,
    output cpu_pkg::word_t imem_addr_o,
    input  cpu_pkg::word_t imem_data_i,
    output cpu_pkg::word_t dmem_addr_o,
    output cpu_pkg::word_t dmem_data_o,
    output logic           data_wren_o,
    input  cpu_pkg::word_t dmem_q_i
);

    cpu_pkg::fd_reg_t  fd;
    cpu_pkg::dx_reg_t  dx;
    cpu_pkg::xm_reg_t  xm;
    cpu_pkg::mw_reg_t  mw;
    cpu_pkg::reg_idx_t rd_addr_a;
    cpu_pkg::reg_idx_t rd_addr_b;
    cpu_pkg::word_t    rd_data_a;
    cpu_pkg::word_t    rd_data_b;
    cpu_pkg::word_t    jump_target;
    cpu_pkg::opcode_t  mw_opc;
    cpu_pkg::reg_idx_t wb_addr;
    cpu_pkg::word_t    wb_data;
    logic              wb_en;
    logic              stall;
    logic              jump_taken;

    fetch_stage fetch (
        .clock_i(clock_i), .arst_n_i(arst_n_i), .stall_i(stall),
        .jump_taken_i(jump_taken), .jump_target_i(jump_target),
        .imem_data_i(imem_data_i), .imem_addr_o(imem_addr_o), .fd_o(fd)
    );

    decode_stage decode (
        .clock_i(clock_i), .arst_n_i(arst_n_i), .fd_i(fd), .jump_taken_i(jump_taken),
        .rd_data_a_i(rd_data_a), .rd_data_b_i(rd_data_b),
        .rd_addr_a_o(rd_addr_a), .rd_addr_b_o(rd_addr_b), .stall_o(stall), .dx_o(dx)
    );

    reg_file regs (
        .clock_i(clock_i), .arst_n_i(arst_n_i),
        .wr_en_i(wb_en), .wr_addr_i(wb_addr), .wr_data_i(wb_data),
        .rd_addr_a_i(rd_addr_a), .rd_addr_b_i(rd_addr_b),
        .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b)
    );

    execute_stage xecute (
        .clock_i(clock_i), .arst_n_i(arst_n_i), .dx_i(dx), .xm_o(xm),
        .wb_en_i(wb_en), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
        .jump_taken_o(jump_taken), .jump_target_o(jump_target)
    );

    memory_stage memory (
        .clock_i(clock_i), .arst_n_i(arst_n_i), .xm_i(xm),
        .wb_en_i(wb_en), .wb_addr_i(wb_addr), .wb_data_i(wb_data),
        .dmem_addr_o(dmem_addr_o), .dmem_data_o(dmem_data_o), .data_wren_o(data_wren_o),
        .dmem_q_i(dmem_q_i), .mw_o(mw)
    );

    // writeback from mw
    assign mw_opc  = mw.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign wb_addr = (mw_opc == cpu_pkg::OP_JAL) ? cpu_pkg::LINK_REG
                                                 : mw.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];
    assign wb_data = (mw_opc == cpu_pkg::OP_LW) ? mw.d : mw.o;
    assign wb_en   = ((mw_opc == cpu_pkg::OP_RTYPE) || (mw_opc == cpu_pkg::OP_ADDI)
                   || (mw_opc == cpu_pkg::OP_LW) || (mw_opc == cpu_pkg::OP_JAL))
                   && (wb_addr != '0);  // r0 writes dropped here

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    localparam int WORD_W   = 32;
    localparam int REG_W    = 5;
    localparam int OPC_W    = 5;
    localparam int NUM_REGS = 32;

    typedef logic [WORD_W-1:0] word_t;    // data word or address
    typedef logic [REG_W-1:0]  reg_idx_t; // register number
    typedef logic [OPC_W-1:0]  opcode_t;
    typedef logic [4:0]        alu_op_t;  // R-type function field

    // instruction field positions
    localparam int OPC_MSB   = 31;
    localparam int RD_LSB    = 22;
    localparam int RS_LSB    = 17;
    localparam int RT_LSB    = 12;
    localparam int SHAMT_LSB = 7;
    localparam int ALUOP_LSB = 2;

    localparam int IMM_WIDTH    = 17;
    localparam int TARGET_WIDTH = 27;

    localparam opcode_t OP_RTYPE = 5'b00000;
    localparam opcode_t OP_J     = 5'b00001;
    localparam opcode_t OP_BNE   = 5'b00010;
    localparam opcode_t OP_JAL   = 5'b00011;
    localparam opcode_t OP_JR    = 5'b00100;
    localparam opcode_t OP_ADDI  = 5'b00101;
    localparam opcode_t OP_BLT   = 5'b00110;
    localparam opcode_t OP_SW    = 5'b00111;
    localparam opcode_t OP_LW    = 5'b01000;

    localparam alu_op_t ALU_ADD = 5'd0;
    localparam alu_op_t ALU_SUB = 5'd1;
    localparam alu_op_t ALU_AND = 5'd2;
    localparam alu_op_t ALU_OR  = 5'd3;
    localparam alu_op_t ALU_SLL = 5'd4;
    localparam alu_op_t ALU_SRA = 5'd5;

    localparam reg_idx_t LINK_REG  = 5'd31;
    localparam word_t    NOP_INSTR = '0;     // add r0,r0,r0

    typedef struct packed {
        word_t instr;
        word_t pc_p1;
    } fd_reg_t;

    typedef struct packed {
        word_t instr;
        word_t pc_p1;
        word_t a;
        word_t b;
    } dx_reg_t;

    typedef struct packed {
        word_t instr;
        word_t o;     // alu result or link value
        word_t b;     // store value
    } xm_reg_t;

    typedef struct packed {
        word_t instr;
        word_t o;
        word_t d;     // loaded data
    } mw_reg_t;

endpackage

// ==== rtl/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic              clock_i,
    input  logic              arst_n_i,
    input  cpu_pkg::fd_reg_t  fd_i,
    input  logic              jump_taken_i,
    input  cpu_pkg::word_t    rd_data_a_i,
    input  cpu_pkg::word_t    rd_data_b_i,
    output cpu_pkg::reg_idx_t rd_addr_a_o,
    output cpu_pkg::reg_idx_t rd_addr_b_o,
    output logic              stall_o,
    output cpu_pkg::dx_reg_t  dx_o
);

    cpu_pkg::dx_reg_t  dx_q;
    cpu_pkg::opcode_t  fd_opc;
    cpu_pkg::opcode_t  dx_opc;
    cpu_pkg::reg_idx_t src_a;
    cpu_pkg::reg_idx_t src_b;
    cpu_pkg::reg_idx_t dx_rd;
    logic              hazard_a;
    logic              hazard_b;

    assign fd_opc = fd_i.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign src_a  = fd_i.instr[cpu_pkg::RS_LSB +: cpu_pkg::REG_W];
    // rd stands in for rt outside R-type (sw data, branch and jr operand)
    assign src_b  = (fd_opc == cpu_pkg::OP_RTYPE) ? fd_i.instr[cpu_pkg::RT_LSB +: cpu_pkg::REG_W]
                                                  : fd_i.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

    assign rd_addr_a_o = src_a;
    assign rd_addr_b_o = src_b;

    assign dx_opc = dx_q.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign dx_rd  = dx_q.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

    assign hazard_a = (src_a != '0) && (src_a == dx_rd);
    assign hazard_b = (src_b != '0) && (src_b == dx_rd) && (fd_opc != cpu_pkg::OP_SW); // mem bypass
    assign stall_o  = (dx_opc == cpu_pkg::OP_LW) && (hazard_a || hazard_b);

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dx_q <= '{instr: cpu_pkg::NOP_INSTR, pc_p1: '0, a: '0, b: '0};
        end else begin
            dx_q.instr <= (stall_o || jump_taken_i) ? cpu_pkg::NOP_INSTR : fd_i.instr; // bubble
            dx_q.pc_p1 <= fd_i.pc_p1;
            dx_q.a     <= rd_data_a_i;
            dx_q.b     <= rd_data_b_i;
        end
    end

    assign dx_o = dx_q;

endmodule

// ==== rtl/execute_alu.sv ====
`timescale 1ns/100ps

module execute_alu (
    input  cpu_pkg::word_t instr_i,
    input  cpu_pkg::word_t a_i,
    input  cpu_pkg::word_t b_i,
    output cpu_pkg::word_t result_o,
    output logic           not_equal_o,
    output logic           less_than_o
);

    cpu_pkg::opcode_t opc;
    cpu_pkg::alu_op_t func;
    cpu_pkg::word_t   imm;
    cpu_pkg::word_t   op_a;
    cpu_pkg::word_t   op_b;
    cpu_pkg::word_t   diff;
    logic [4:0]       shamt;
    logic             is_rtype;
    logic             is_branch;
    logic             use_imm;
    logic             ovf;

    assign opc       = instr_i[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign is_rtype  = (opc == cpu_pkg::OP_RTYPE);
    assign is_branch = (opc == cpu_pkg::OP_BNE) || (opc == cpu_pkg::OP_BLT);
    assign use_imm   = (opc == cpu_pkg::OP_ADDI) || (opc == cpu_pkg::OP_LW)
                    || (opc == cpu_pkg::OP_SW);

    assign imm = {{(cpu_pkg::WORD_W - cpu_pkg::IMM_WIDTH){instr_i[cpu_pkg::IMM_WIDTH-1]}},
                  instr_i[cpu_pkg::IMM_WIDTH-1:0]};

    // branches compare rd against rs, so the operands swap
    assign op_a = is_branch ? b_i : a_i;
    assign op_b = is_branch ? a_i : (use_imm ? imm : b_i);

    assign func  = is_rtype  ? instr_i[cpu_pkg::ALUOP_LSB +: 5]
                 : is_branch ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
    assign shamt = instr_i[cpu_pkg::SHAMT_LSB +: 5];
    assign diff  = op_a - op_b;

    always_comb begin
        case (func)
            cpu_pkg::ALU_ADD: result_o = op_a + op_b;
            cpu_pkg::ALU_SUB: result_o = diff;
            cpu_pkg::ALU_AND: result_o = op_a & op_b;
            cpu_pkg::ALU_OR:  result_o = op_a | op_b;
            cpu_pkg::ALU_SLL: result_o = op_a << shamt;
            cpu_pkg::ALU_SRA: result_o = cpu_pkg::word_t'($signed(op_a) >>> shamt);
            default:          result_o = '0;          // unused codes read as zero
        endcase
    end

    // signed less-than from the subtract, corrected for overflow
    assign ovf         = (op_a[cpu_pkg::WORD_W-1] != op_b[cpu_pkg::WORD_W-1])
                      && (diff[cpu_pkg::WORD_W-1] != op_a[cpu_pkg::WORD_W-1]);
    assign less_than_o = diff[cpu_pkg::WORD_W-1] ^ ovf;
    assign not_equal_o = |diff;

endmodule

// ==== rtl/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic              clock_i,
    input  logic              arst_n_i,
    input  cpu_pkg::dx_reg_t  dx_i,
    output cpu_pkg::xm_reg_t  xm_o,
    input  logic              wb_en_i,
    input  cpu_pkg::reg_idx_t wb_addr_i,
    input  cpu_pkg::word_t    wb_data_i,
    output logic              jump_taken_o,
    output cpu_pkg::word_t    jump_target_o
);

    cpu_pkg::xm_reg_t  xm_q;
    cpu_pkg::opcode_t  opc;
    cpu_pkg::reg_idx_t num_a;
    cpu_pkg::reg_idx_t num_b;
    cpu_pkg::word_t    a_fwd;
    cpu_pkg::word_t    b_fwd;
    cpu_pkg::word_t    alu_res;
    cpu_pkg::word_t    imm;
    cpu_pkg::word_t    target;
    logic              ne;
    logic              lt;
    logic              is_j;
    logic              is_jal;
    logic              is_jr;
    logic              is_bne;
    logic              is_blt;

    assign opc    = dx_i.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign is_j   = (opc == cpu_pkg::OP_J);
    assign is_jal = (opc == cpu_pkg::OP_JAL);
    assign is_jr  = (opc == cpu_pkg::OP_JR);
    assign is_bne = (opc == cpu_pkg::OP_BNE);
    assign is_blt = (opc == cpu_pkg::OP_BLT);

    assign num_a = dx_i.instr[cpu_pkg::RS_LSB +: cpu_pkg::REG_W];
    assign num_b = (opc == cpu_pkg::OP_RTYPE) ? dx_i.instr[cpu_pkg::RT_LSB +: cpu_pkg::REG_W]
                                              : dx_i.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

    operand_bypass get_alu_a (
        .reg_num_i(num_a), .reg_val_i(dx_i.a), .xm_i(xm_q),
        .wb_en_i(wb_en_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i), .operand_o(a_fwd)
    );

    operand_bypass get_alu_b (
        .reg_num_i(num_b), .reg_val_i(dx_i.b), .xm_i(xm_q),
        .wb_en_i(wb_en_i), .wb_addr_i(wb_addr_i), .wb_data_i(wb_data_i), .operand_o(b_fwd)
    );

    execute_alu alu_section (
        .instr_i(dx_i.instr), .a_i(a_fwd), .b_i(b_fwd),
        .result_o(alu_res), .not_equal_o(ne), .less_than_o(lt)
    );

    assign imm    = {{(cpu_pkg::WORD_W - cpu_pkg::IMM_WIDTH){dx_i.instr[cpu_pkg::IMM_WIDTH-1]}},
                     dx_i.instr[cpu_pkg::IMM_WIDTH-1:0]};
    assign target = {{(cpu_pkg::WORD_W - cpu_pkg::TARGET_WIDTH){
                         dx_i.instr[cpu_pkg::TARGET_WIDTH-1]}},
                     dx_i.instr[cpu_pkg::TARGET_WIDTH-1:0]};

    assign jump_taken_o  = is_j || is_jal || is_jr || (is_bne && ne) || (is_blt && lt);
    assign jump_target_o = (is_bne || is_blt) ? dx_i.pc_p1 + imm  // pc-relative
                         : is_jr              ? b_fwd             // rd value
                                              : target;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            xm_q <= '{instr: cpu_pkg::NOP_INSTR, o: '0, b: '0};
        end else begin
            xm_q.instr <= dx_i.instr;
            xm_q.o     <= is_jal ? dx_i.pc_p1 : alu_res; // link value for jal
            xm_q.b     <= b_fwd;
        end
    end

    assign xm_o = xm_q;

endmodule

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/100ps

module fetch_stage (
    input  logic             clock_i,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             jump_taken_i,
    input  cpu_pkg::word_t   jump_target_i,
    input  cpu_pkg::word_t   imem_data_i,
    output cpu_pkg::word_t   imem_addr_o,
    output cpu_pkg::fd_reg_t fd_o
);

    cpu_pkg::word_t   pc_q;
    cpu_pkg::word_t   pc_p1;
    cpu_pkg::fd_reg_t fd_q;

    assign pc_p1 = pc_q + cpu_pkg::word_t'(1);

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= '0;
            fd_q <= '{instr: cpu_pkg::NOP_INSTR, pc_p1: '0};
        end else if (jump_taken_i) begin
            pc_q <= jump_target_i;
            fd_q <= '{instr: cpu_pkg::NOP_INSTR, pc_p1: pc_p1}; // squash fetched word
        end else if (!stall_i) begin
            pc_q <= pc_p1;
            fd_q <= '{instr: imem_data_i, pc_p1: pc_p1};
        end
    end

    assign imem_addr_o = pc_q;
    assign fd_o        = fd_q;

endmodule

// ==== rtl/memory_stage.sv ====
`timescale 1ns/100ps

module memory_stage (
    input  logic              clock_i,
    input  logic              arst_n_i,
    input  cpu_pkg::xm_reg_t  xm_i,
    input  logic              wb_en_i,
    input  cpu_pkg::reg_idx_t wb_addr_i,
    input  cpu_pkg::word_t    wb_data_i,
    output cpu_pkg::word_t    dmem_addr_o,
    output cpu_pkg::word_t    dmem_data_o,
    output logic              data_wren_o,
    input  cpu_pkg::word_t    dmem_q_i,
    output cpu_pkg::mw_reg_t  mw_o
);

    cpu_pkg::mw_reg_t  mw_q;
    cpu_pkg::opcode_t  opc;
    cpu_pkg::reg_idx_t store_rd;
    logic              fwd_store;

    assign opc      = xm_i.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign store_rd = xm_i.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

    assign dmem_addr_o = xm_i.o;
    assign data_wren_o = (opc == cpu_pkg::OP_SW);

    // covers a lw feeding the very next sw
    assign fwd_store   = wb_en_i && (wb_addr_i == store_rd);
    assign dmem_data_o = fwd_store ? wb_data_i : xm_i.b;

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mw_q <= '{instr: cpu_pkg::NOP_INSTR, o: '0, d: '0};
        end else begin
            mw_q <= '{instr: xm_i.instr, o: xm_i.o, d: dmem_q_i};
        end
    end

    assign mw_o = mw_q;

endmodule

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/100ps

module operand_bypass (
    input  cpu_pkg::reg_idx_t reg_num_i,
    input  cpu_pkg::word_t    reg_val_i,
    input  cpu_pkg::xm_reg_t  xm_i,
    input  logic              wb_en_i,
    input  cpu_pkg::reg_idx_t wb_addr_i,
    input  cpu_pkg::word_t    wb_data_i,
    output cpu_pkg::word_t    operand_o
);

    cpu_pkg::opcode_t  xm_opc;
    cpu_pkg::reg_idx_t xm_dest;
    logic              xm_writes;
    logic              use_xm;
    logic              use_wb;

    assign xm_opc  = xm_i.instr[cpu_pkg::OPC_MSB -: cpu_pkg::OPC_W];
    assign xm_dest = (xm_opc == cpu_pkg::OP_JAL) ? cpu_pkg::LINK_REG
                                                 : xm_i.instr[cpu_pkg::RD_LSB +: cpu_pkg::REG_W];

    // lw left out, its data only exists one stage later
    assign xm_writes = (xm_opc == cpu_pkg::OP_RTYPE) || (xm_opc == cpu_pkg::OP_ADDI)
                    || (xm_opc == cpu_pkg::OP_JAL);

    assign use_xm = xm_writes && (xm_dest != '0) && (xm_dest == reg_num_i);
    assign use_wb = wb_en_i && (wb_addr_i == reg_num_i);          // wb_en excludes r0

    assign operand_o = use_xm ? xm_i.o : (use_wb ? wb_data_i : reg_val_i); // youngest wins

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic              clock_i,
    input  logic              arst_n_i,
    input  logic              wr_en_i,
    input  cpu_pkg::reg_idx_t wr_addr_i,
    input  cpu_pkg::word_t    wr_data_i,
    input  cpu_pkg::reg_idx_t rd_addr_a_i,
    input  cpu_pkg::reg_idx_t rd_addr_b_i,
    output cpu_pkg::word_t    rd_data_a_o,
    output cpu_pkg::word_t    rd_data_b_o
);

    cpu_pkg::word_t regs_q [cpu_pkg::NUM_REGS];
    logic           wr_ok;
    logic           hit_a;
    logic           hit_b;

    assign wr_ok = wr_en_i && (wr_addr_i != '0); // r0 never written

    always_ff @(posedge clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < cpu_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_ok) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    // write-through so decode sees the value retiring this cycle
    assign hit_a = wr_ok && (wr_addr_i == rd_addr_a_i);
    assign hit_b = wr_ok && (wr_addr_i == rd_addr_b_i);

    assign rd_data_a_o = hit_a ? wr_data_i : regs_q[rd_addr_a_i];
    assign rd_data_b_o = hit_b ? wr_data_i : regs_q[rd_addr_b_i];

endmodule

// ==== tests/tb_cpu_core.sv ====
`timescale 1ns/100ps

module tb_cpu_core;

    localparam int NUM_PROGS    = 5;
    localparam int PROG_LEN     = 24;
    localparam int MAX_STORES   = 8;
    localparam int MEM_WORDS    = 64;
    localparam int CLK_PERIOD   = 20;
    localparam int DRIVE_DELAY  = 2;    // ns after the rising edge
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES   = 60;
    localparam int WATCHDOG_NS  = (NUM_PROGS + 1) * (RESET_CYCLES + RUN_CYCLES) * CLK_PERIOD;

    logic           clock;
    logic           arst_n;
    logic           data_wren;
    cpu_pkg::word_t imem_addr;
    cpu_pkg::word_t imem_data;
    cpu_pkg::word_t dmem_addr;
    cpu_pkg::word_t dmem_data;
    cpu_pkg::word_t dmem_q;

    cpu_pkg::word_t imem [MEM_WORDS];
    cpu_pkg::word_t dmem [MEM_WORDS];

    // one program per entry, with the stores it must produce in order
    cpu_pkg::word_t prog_tab [NUM_PROGS][PROG_LEN];
    int             prog_len [NUM_PROGS];
    cpu_pkg::word_t exp_addr [NUM_PROGS][MAX_STORES];
    cpu_pkg::word_t exp_data [NUM_PROGS][MAX_STORES];
    int             exp_cnt  [NUM_PROGS];

    logic [31:0] rng_state;
    int          value_errs;
    int          count_errs;
    int          stores_seen;

    cpu_core dut0 (
        .clock_i(clock), .arst_n_i(arst_n),
        .imem_addr_o(imem_addr), .imem_data_i(imem_data),
        .dmem_addr_o(dmem_addr), .dmem_data_o(dmem_data),
        .data_wren_o(data_wren), .dmem_q_i(dmem_q)
    );

    assign imem_data = imem[imem_addr[5:0]]; // combinational read
    assign dmem_q    = dmem[dmem_addr[5:0]];

    always #(CLK_PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_pkg::word_t fill_word(input int a);
        return (cpu_pkg::word_t'(a) * 32'h9e37_79b9) ^ 32'h5a5a_0000;
    endfunction

    function automatic cpu_pkg::word_t rtype_word(input cpu_pkg::alu_op_t func, input int rd,
                                                  input int rs, input int rt, input int shamt);
        return {cpu_pkg::OP_RTYPE, 5'(rd), 5'(rs), 5'(rt), 5'(shamt), func, 2'b00};
    endfunction

    function automatic cpu_pkg::word_t itype_word(input cpu_pkg::opcode_t opc, input int rd,
                                                  input int rs, input cpu_pkg::word_t imm);
        return {opc, 5'(rd), 5'(rs), 17'(imm)};
    endfunction

    function automatic cpu_pkg::word_t jtype_word(input cpu_pkg::opcode_t opc, input int target);
        return {opc, 27'(target)};
    endfunction

    task automatic draw_imm(output cpu_pkg::word_t k);
        rng_state = xorshift32(rng_state);
        k = {{15{rng_state[16]}}, rng_state[16:0]}; // 17-bit signed immediate
    endtask

    task automatic add_instr(input int p, input cpu_pkg::word_t w);
        prog_tab[p][prog_len[p]] = w;
        prog_len[p]++;
    endtask

    task automatic expect_store(input int p, input int a, input cpu_pkg::word_t d);
        exp_addr[p][exp_cnt[p]] = cpu_pkg::word_t'(a);
        exp_data[p][exp_cnt[p]] = d;
        exp_cnt[p]++;
    endtask

    task automatic build_table();
        cpu_pkg::word_t k [8];
        cpu_pkg::word_t v [16];
        for (int p = 0; p < NUM_PROGS; p++) begin
            prog_len[p] = 0;
            exp_cnt[p]  = 0;
        end
        // alu chain through xm and wb forwarding
        draw_imm(k[0]);
        draw_imm(k[1]);
        add_instr(0, itype_word(cpu_pkg::OP_ADDI, 1, 0, k[0]));
        add_instr(0, itype_word(cpu_pkg::OP_ADDI, 2, 0, k[1]));
        add_instr(0, rtype_word(cpu_pkg::ALU_ADD, 3, 1, 2, 0));
        add_instr(0, rtype_word(cpu_pkg::ALU_SUB, 4, 3, 1, 0));
        add_instr(0, rtype_word(cpu_pkg::ALU_AND, 5, 4, 3, 0));
        add_instr(0, rtype_word(cpu_pkg::ALU_OR, 6, 5, 2, 0));
        add_instr(0, rtype_word(cpu_pkg::ALU_SLL, 7, 6, 0, 3));
        add_instr(0, rtype_word(cpu_pkg::ALU_SRA, 8, 7, 0, 2));
        v[3] = k[0] + k[1];
        v[4] = v[3] - k[0];
        v[5] = v[4] & v[3];
        v[6] = v[5] | k[1];
        v[7] = v[6] << 3;
        v[8] = cpu_pkg::word_t'($signed(v[7]) >>> 2);
        for (int r = 3; r <= 8; r++) begin
            add_instr(0, itype_word(cpu_pkg::OP_SW, r, 0, cpu_pkg::word_t'(37 + r)));
            expect_store(0, 37 + r, v[r]);
        end
        // loads, load-use bubble and store data from writeback
        draw_imm(k[2]);
        v[1] = fill_word(5);
        v[2] = v[1] + v[1];
        v[3] = fill_word(6);
        v[4] = v[3] + k[2];
        add_instr(1, itype_word(cpu_pkg::OP_LW, 1, 0, 5));
        add_instr(1, rtype_word(cpu_pkg::ALU_ADD, 2, 1, 1, 0)); // needs the bubble
        add_instr(1, itype_word(cpu_pkg::OP_SW, 2, 0, 46));
        add_instr(1, itype_word(cpu_pkg::OP_LW, 3, 0, 6));
        add_instr(1, itype_word(cpu_pkg::OP_SW, 3, 0, 47));     // data from writeback
        add_instr(1, itype_word(cpu_pkg::OP_ADDI, 4, 3, k[2]));
        add_instr(1, itype_word(cpu_pkg::OP_SW, 4, 0, 48));
        add_instr(1, itype_word(cpu_pkg::OP_SW, 1, 0, 49));
        add_instr(1, itype_word(cpu_pkg::OP_LW, 5, 0, 46));     // reads back first store
        add_instr(1, itype_word(cpu_pkg::OP_SW, 5, 0, 50));
        expect_store(1, 46, v[2]);
        expect_store(1, 47, v[3]);
        expect_store(1, 48, v[4]);
        expect_store(1, 49, v[1]);
        expect_store(1, 50, v[2]);
        // r3 = r1 + 1, so every branch outcome is fixed
        draw_imm(k[3]);
        v[1] = k[3];
        v[3] = k[3] + 32'd1;
        add_instr(2, itype_word(cpu_pkg::OP_ADDI, 1, 0, k[3]));
        add_instr(2, itype_word(cpu_pkg::OP_ADDI, 3, 1, 1));
        add_instr(2, itype_word(cpu_pkg::OP_BNE, 1, 1, 2));     // equal, falls through
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 40));
        add_instr(2, itype_word(cpu_pkg::OP_BNE, 3, 1, 2));     // taken to 7
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 41));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 3, 0, 42));
        add_instr(2, itype_word(cpu_pkg::OP_BLT, 3, 1, 2));     // not less, falls through
        add_instr(2, itype_word(cpu_pkg::OP_SW, 3, 0, 43));
        add_instr(2, itype_word(cpu_pkg::OP_BLT, 1, 3, 2));     // taken to 12
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 44));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 45));
        add_instr(2, jtype_word(cpu_pkg::OP_J, 15));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 46));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 3, 0, 47));
        add_instr(2, itype_word(cpu_pkg::OP_ADDI, 4, 0, 19));
        add_instr(2, itype_word(cpu_pkg::OP_JR, 4, 0, 0));      // target forwarded from xm
        add_instr(2, itype_word(cpu_pkg::OP_SW, 1, 0, 48));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 3, 0, 49));
        add_instr(2, itype_word(cpu_pkg::OP_SW, 4, 0, 50));
        expect_store(2, 40, v[1]);
        expect_store(2, 43, v[3]);
        expect_store(2, 50, 32'd19);
        // jal link values
        draw_imm(k[4]);
        add_instr(3, itype_word(cpu_pkg::OP_ADDI, 1, 0, k[4]));
        add_instr(3, jtype_word(cpu_pkg::OP_JAL, 5));           // link is 2
        add_instr(3, itype_word(cpu_pkg::OP_SW, 1, 0, 40));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 1, 0, 41));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 1, 0, 42));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 31, 0, 43));
        add_instr(3, rtype_word(cpu_pkg::ALU_ADD, 2, 31, 1, 0));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 2, 0, 44));
        add_instr(3, jtype_word(cpu_pkg::OP_JAL, 11));          // link is 9
        add_instr(3, itype_word(cpu_pkg::OP_SW, 1, 0, 45));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 2, 0, 46));
        add_instr(3, itype_word(cpu_pkg::OP_SW, 31, 0, 47));
        expect_store(3, 43, 32'd2);
        expect_store(3, 44, 32'd2 + k[4]);
        expect_store(3, 47, 32'd9);
        // forwarded base registers, store then load back
        draw_imm(k[5]);
        draw_imm(k[6]);
        v[11] = k[5] + k[6];
        v[12] = k[5] - v[11];
        v[13] = cpu_pkg::word_t'($signed(v[12]) >>> 4);
        add_instr(4, itype_word(cpu_pkg::OP_ADDI, 10, 0, k[5]));
        add_instr(4, itype_word(cpu_pkg::OP_ADDI, 11, 10, k[6]));
        add_instr(4, rtype_word(cpu_pkg::ALU_SUB, 12, 10, 11, 0));
        add_instr(4, rtype_word(cpu_pkg::ALU_SRA, 13, 12, 0, 4));
        add_instr(4, itype_word(cpu_pkg::OP_SW, 13, 0, 50));
        add_instr(4, itype_word(cpu_pkg::OP_ADDI, 14, 0, 52));
        add_instr(4, itype_word(cpu_pkg::OP_SW, 12, 14, 0));
        add_instr(4, itype_word(cpu_pkg::OP_LW, 15, 14, 0));
        add_instr(4, itype_word(cpu_pkg::OP_SW, 15, 14, 1));
        add_instr(4, itype_word(cpu_pkg::OP_LW, 16, 0, 53));
        add_instr(4, itype_word(cpu_pkg::OP_ADDI, 17, 16, 1));
        add_instr(4, itype_word(cpu_pkg::OP_SW, 17, 14, 2));
        expect_store(4, 50, v[13]);
        expect_store(4, 52, v[12]);
        expect_store(4, 53, v[12]);
        expect_store(4, 54, v[12] + 32'd1);
    endtask

    task automatic load_memories(input int p);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < prog_len[p]) begin
                imem[i] = prog_tab[p][i];
            end else begin
                imem[i] = jtype_word(cpu_pkg::OP_J, i); // park on j-to-self
            end
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic check_idle(input string when_txt);
        if (imem_addr !== 32'h0) begin
            $display("[FAIL] %s imem_addr_o: got %h expected %h", when_txt, imem_addr, 32'h0);
            value_errs++;
        end
        if (data_wren !== 1'b0) begin
            $display("[FAIL] %s data_wren_o: got %h expected %h", when_txt, data_wren, 1'b0);
            value_errs++;
        end
    endtask

    task automatic check_store(input int p, input int idx);
        if (idx >= exp_cnt[p]) begin
            $display("program %0d: extra store to address %h with data %h",
                     p, dmem_addr, dmem_data);
            count_errs++;
        end else begin
            if (dmem_addr !== exp_addr[p][idx]) begin
                $display("[FAIL] program %0d store %0d dmem_addr_o: got %h expected %h",
                         p, idx, dmem_addr, exp_addr[p][idx]);
                value_errs++;
            end
            if (dmem_data !== exp_data[p][idx]) begin
                $display("[FAIL] program %0d store %0d dmem_data_o: got %h expected %h",
                         p, idx, dmem_data, exp_data[p][idx]);
                value_errs++;
            end
        end
    endtask

    task automatic run_program(input int p);
        int seen;
        seen = 0;
        @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b0;
        load_memories(p);
        #1;
        check_idle($sformatf("program %0d in reset:", p));
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        repeat (RUN_CYCLES) begin
            @(negedge clock);   // outputs settled mid-cycle
            if (data_wren === 1'b1) begin
                check_store(p, seen);
                dmem[dmem_addr[5:0]] = dmem_data; // visible to later loads
                seen++;
            end
        end
        if (seen < exp_cnt[p]) begin
            $display("program %0d: only %0d of %0d expected stores were seen",
                     p, seen, exp_cnt[p]);
            count_errs++;
        end
        stores_seen += seen;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not end within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clock       = 1'b0;
        arst_n      = 1'b1;
        rng_state   = 32'd80172;
        value_errs  = 0;
        count_errs  = 0;
        stores_seen = 0;
        build_table();
        load_memories(0);
        #DRIVE_DELAY;
        arst_n = 1'b0;        // reset edge before the first clock
        #1;
        check_idle("before first clock:");
        for (int p = 0; p < NUM_PROGS; p++) begin
            run_program(p);
        end
        $display("stores seen: %0d, value errors: %0d, store count errors: %0d",
                 stores_seen, value_errs, count_errs);
        if (value_errs + count_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
